/* src/rtWritePkg.sv */
// Sizes, bus addresses, sequencer timing, block writer state codes and the quadlet union
`default_nettype none

package rtWritePkg;

   // Motor channels and the width of a channel index
   localparam int NumMotors = 4;
   localparam int ChanBits = $clog2(NumMotors);

   // Real-time write address, index NumMotors carries the power-control quadlet
   localparam int AddrBits = 4;

   // Power-control bits kept from the control quadlet
   localparam int CtrlBits = 20;

   // Register bus addresses
   // Channel page offset for the DAC quadlet
   localparam logic [3:0] OffDacCtrl = 4'd1;
   localparam logic [7:0] AddrPowerCtrl = 8'h00;

   // Terminal count of the 2-bit phase counter, 4 cycles per phase
   localparam logic [1:0] StrobeGap = 2'd3;

   // Block writer states
   localparam logic [2:0] BwIdle = 3'd0;
   localparam logic [2:0] BwStart = 3'd1;
   localparam logic [2:0] BwWrite = 3'd2;
   localparam logic [2:0] BwWriteGap = 3'd3;
   localparam logic [2:0] BwBlkWen = 3'd4;
   localparam logic [2:0] BwQuadGap = 3'd5;
   localparam logic [2:0] BwQuad = 3'd6;

   // One quadlet, read as a DAC quadlet at a channel page or as the power-control word
   typedef union packed {
      struct packed {
         logic        dacValid;
         logic        rsvdHi;
         logic        ampEnMask;
         logic        ampEn;
         logic [11:0] rsvdMid;
         logic [15:0] dacValue;
      } dac;
      struct packed {
         logic [31-CtrlBits:0] rsvd;
         logic [CtrlBits-1:0]  powerCtrl;
      } ctrl;
   } rtQuadletU;

endpackage

`default_nettype wire

/* src/fwRtReceiver.sv */
// Firewire real-time receiver: quadlet index and addressed write output
`timescale 1ns/1ns
`default_nettype none

module fwRtReceiver import rtWritePkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  logic                fwBlockStart,
   input  logic                fwQuadValid,
   input  logic [31:0]         fwQuadData,
   output logic                fwWriteEn,
   output logic [AddrBits-1:0] fwWriteAddr,
   output logic [31:0]         fwWriteData
);

   // Next quadlet index, parked at NumMotors + 1 when no block is open
   logic [AddrBits-1:0] quadIdx;
   logic [AddrBits-1:0] curIdx;
   logic                inBlock;

   // Start pulse with a quadlet in the same cycle makes it quadlet 0
   assign curIdx = fwBlockStart ? '0 : quadIdx;
   // Indices 0 to NumMotors are kept, later ones are dropped
   assign inBlock = curIdx <= AddrBits'(NumMotors);

   always_ff @(posedge clk) begin
      if (rst) begin
         quadIdx <= AddrBits'(NumMotors + 1);
         fwWriteEn <= 1'b0;
      end else begin
         fwWriteEn <= fwQuadValid && inBlock;
         if (fwQuadValid && inBlock) begin
            quadIdx <= curIdx + 1'b1;
         end else if (fwBlockStart) begin
            quadIdx <= '0;
         end
      end
   end

   // Address and data captured alongside the enable
   always_ff @(posedge clk) begin
      if (fwQuadValid) begin
         fwWriteAddr <= curIdx;
         fwWriteData <= fwQuadData;
      end
   end

endmodule

`default_nettype wire

/* src/ethRtReceiver.sv */
// Ethernet real-time receiver: halfword pairing, quadlet index and addressed write output
`timescale 1ns/1ns
`default_nettype none

module ethRtReceiver import rtWritePkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  logic                ethFrameStart,
   input  logic                ethHalfValid,
   input  logic [15:0]         ethHalfData,
   output logic                ethWriteEn,
   output logic [AddrBits-1:0] ethWriteAddr,
   output logic [31:0]         ethWriteData
);

   // Next quadlet index, parked past the control index outside a frame
   logic [AddrBits-1:0] quadIdx;
   logic [AddrBits-1:0] curIdx;
   // Low when the next halfword is a high half
   logic                phase;
   logic                curPhase;
   logic [15:0]         highHalf;
   logic                quadDone;
   logic                inBlock;

   // Frame start restarts pairing and indexing in its own cycle
   assign curIdx = ethFrameStart ? '0 : quadIdx;
   assign curPhase = ethFrameStart ? 1'b0 : phase;

   // Second halfword of a pair completes a quadlet
   assign quadDone = ethHalfValid && curPhase;
   assign inBlock = curIdx <= AddrBits'(NumMotors);

   always_ff @(posedge clk) begin
      if (rst) begin
         quadIdx <= AddrBits'(NumMotors + 1);
         phase <= 1'b0;
         ethWriteEn <= 1'b0;
      end else begin
         ethWriteEn <= quadDone && inBlock;
         if (ethHalfValid) begin
            phase <= !curPhase;
         end else if (ethFrameStart) begin
            phase <= 1'b0;
         end
         if (quadDone && inBlock) begin
            quadIdx <= curIdx + 1'b1;
         end else if (ethFrameStart) begin
            quadIdx <= '0;
         end
      end
   end

   // High half waits for its low half
   always_ff @(posedge clk) begin
      if (ethHalfValid && !curPhase) begin
         highHalf <= ethHalfData;
      end
      if (quadDone) begin
         ethWriteAddr <= curIdx;
         ethWriteData <= {highHalf, ethHalfData};
      end
   end

endmodule

`default_nettype wire

/* src/rtSourceSelect.sv */
// Link selector: per-block grant between the two receivers, collision flag, registered output
`timescale 1ns/1ns
`default_nettype none

module rtSourceSelect import rtWritePkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  logic                fwWriteEn,
   input  logic [AddrBits-1:0] fwWriteAddr,
   input  logic [31:0]         fwWriteData,
   input  logic                ethWriteEn,
   input  logic [AddrBits-1:0] ethWriteAddr,
   input  logic [31:0]         ethWriteData,
   output logic                rtWriteEn,
   output logic [AddrBits-1:0] rtWriteAddr,
   output logic [31:0]         rtWriteData,
   output logic                hostConflict
);

   // Grant held by a link until its control quadlet passes
   logic grantFw;
   logic grantEth;
   logic selFw;
   logic selEth;

   // Firewire passes unless Ethernet holds the grant, so it wins a tie when idle
   assign selFw = fwWriteEn && !grantEth;
   assign selEth = ethWriteEn && !grantFw && !selFw;

   always_ff @(posedge clk) begin
      if (rst) begin
         grantFw <= 1'b0;
         grantEth <= 1'b0;
         rtWriteEn <= 1'b0;
         hostConflict <= 1'b0;
      end else begin
         rtWriteEn <= selFw || selEth;
         // Grant released by the write to the control index
         if (selFw) begin
            grantFw <= fwWriteAddr != AddrBits'(NumMotors);
         end
         if (selEth) begin
            grantEth <= ethWriteAddr != AddrBits'(NumMotors);
         end
         // Sticky until reset
         if ((fwWriteEn && !selFw) || (ethWriteEn && !selEth)) begin
            hostConflict <= 1'b1;
         end
      end
   end

   // Forwarded payload of the selected link
   always_ff @(posedge clk) begin
      if (selFw) begin
         rtWriteAddr <= fwWriteAddr;
         rtWriteData <= fwWriteData;
      end else if (selEth) begin
         rtWriteAddr <= ethWriteAddr;
         rtWriteData <= ethWriteData;
      end
   end

endmodule

`default_nettype wire

/* src/rtBlockWriter.sv */
// Real-time block writer with DAC quadlet store and register-bus write sequencer
`timescale 1ns/1ns
`default_nettype none

module rtBlockWriter import rtWritePkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  logic                rtWriteEn,
   input  logic [AddrBits-1:0] rtWriteAddr,
   input  logic [31:0]         rtWriteData,
   output logic                bwRegWen,
   output logic                bwBlockWen,
   output logic                bwBlockWstart,
   output logic [7:0]          bwRegWaddr,
   output logic [31:0]         bwRegWdata,
   output logic                dacUpdate,
   output logic                rtBusy
);

   logic [2:0]          rtState;
   // Phase counter that restarts in idle and on each register write
   logic [1:0]          rtCnt;
   // Channel being replayed
   logic [ChanBits-1:0] chanIdx;
   // Kept bits of the power-control quadlet
   logic [CtrlBits-1:0] rtCtrl;
   // Stored DAC quadlets of the current block
   rtQuadletU           rtDac [NumMotors];
   logic                anyDacValid;
   logic                anyAmpEnMask;
   logic                writeEnd;

   // Any channel with work for the DAC block
   always_comb begin
      anyDacValid = 1'b0;
      anyAmpEnMask = 1'b0;
      for (int i = 0; i < NumMotors; i++) begin
         anyDacValid = anyDacValid | rtDac[i].dac.dacValid;
         anyAmpEnMask = anyAmpEnMask | rtDac[i].dac.ampEnMask;
      end
   end

   // Control quadlet closes the block
   assign writeEnd = rtWriteAddr == AddrBits'(NumMotors);

   // Busy through the last strobe cycle so outputs are settled once it falls
   assign rtBusy = (rtState != BwIdle) || bwRegWen || bwBlockWen;

   always_ff @(posedge clk) begin
      if (rst) begin
         rtState <= BwIdle;
         rtCnt <= 2'd0;
         chanIdx <= '0;
         bwRegWen <= 1'b0;
         bwBlockWen <= 1'b0;
         bwBlockWstart <= 1'b0;
         dacUpdate <= 1'b0;
      end else begin
         // Write gap counts a full phase after the write pulse
         rtCnt <= ((rtState == BwIdle) || (rtState == BwWrite)) ? 2'd0 : rtCnt + 2'd1;
         case (rtState)
            BwIdle: begin
               bwRegWen <= 1'b0;
               bwBlockWen <= 1'b0;
               // Writes during the final strobe cycle are dropped like any busy write
               if (rtWriteEn && !rtBusy) begin
                  if (writeEnd) begin
                     rtCtrl <= rtWriteData[CtrlBits-1:0];
                     if (anyDacValid || anyAmpEnMask) begin
                        bwBlockWstart <= 1'b1;
                        dacUpdate <= anyDacValid;
                        rtState <= BwStart;
                     end else begin
                        // Nothing for the DAC block so only the control quadlet
                        rtState <= BwQuad;
                     end
                  end else if (rtWriteAddr < AddrBits'(NumMotors)) begin
                     rtDac[rtWriteAddr[ChanBits-1:0]] <= rtWriteData;
                  end
               end
            end
            BwStart: begin
               // Start strobe held for one full phase
               if (rtCnt == StrobeGap) begin
                  bwBlockWstart <= 1'b0;
                  dacUpdate <= 1'b0;
                  chanIdx <= '0;
                  rtState <= BwWrite;
               end
            end
            BwWrite: begin
               bwRegWaddr <= {{(4 - ChanBits){1'b0}}, chanIdx, OffDacCtrl};
               bwRegWdata <= rtDac[chanIdx];
               bwRegWen <= 1'b1;
               rtState <= BwWriteGap;
            end
            BwWriteGap: begin
               bwRegWen <= 1'b0;
               // Request bits of the handled channel are spent
               rtDac[chanIdx].dac.dacValid <= 1'b0;
               rtDac[chanIdx].dac.ampEnMask <= 1'b0;
               if (rtCnt == StrobeGap) begin
                  chanIdx <= chanIdx + 1'b1;
                  if (chanIdx == ChanBits'(NumMotors - 1)) begin
                     rtState <= BwBlkWen;
                  end else begin
                     rtState <= BwWrite;
                  end
               end
            end
            BwBlkWen: begin
               // Wait one phase and then commit the block
               if (rtCnt == StrobeGap) begin
                  bwBlockWen <= 1'b1;
                  // Zero control word leaves the power register alone
                  rtState <= (rtCtrl == '0) ? BwIdle : BwQuadGap;
               end
            end
            BwQuadGap: begin
               bwBlockWen <= 1'b0;
               if (rtCnt == StrobeGap) begin
                  rtState <= BwQuad;
               end
            end
            BwQuad: begin
               // Power-control quadlet write with both strobes together
               bwRegWaddr <= AddrPowerCtrl;
               bwRegWdata <= {{(32 - CtrlBits){1'b0}}, rtCtrl};
               bwRegWen <= 1'b1;
               bwBlockWen <= 1'b1;
               rtCtrl <= '0;
               rtState <= BwIdle;
            end
            default: begin
               rtState <= BwIdle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/boardRegisters.sv */
// Board registers: DAC and amp enable staging with block commit, power-control register
`timescale 1ns/1ns
`default_nettype none

module boardRegisters import rtWritePkg::*; (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      bwRegWen,
   input  logic                      bwBlockWen,
   input  logic                      bwBlockWstart,
   input  logic [7:0]                bwRegWaddr,
   input  logic [31:0]               bwRegWdata,
   output logic [16*NumMotors-1:0]   dacValues,
   output logic [NumMotors-1:0]      ampEnable,
   output logic [CtrlBits-1:0]       powerCtrl
);

   // Staged quadlet per channel and whether it arrived in this block
   rtQuadletU            stageQ [NumMotors];
   logic [NumMotors-1:0] stageValid;
   rtQuadletU            busQuad;
   logic [3:0]           page;
   logic [ChanBits-1:0]  chan;
   logic                 stageWr;
   logic                 commitWr;
   logic                 powerWr;

   assign busQuad = bwRegWdata;
   assign page = bwRegWaddr[7:4];
   assign chan = page[ChanBits-1:0];

   // Bus decode
   assign stageWr = bwRegWen && !bwBlockWen && (bwRegWaddr[3:0] == OffDacCtrl)
                    && (page < 4'(NumMotors));
   assign commitWr = bwBlockWen && !bwRegWen;
   assign powerWr = bwRegWen && bwBlockWen && (bwRegWaddr == AddrPowerCtrl);

   always_ff @(posedge clk) begin
      if (stageWr) begin
         stageQ[chan] <= busQuad;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         stageValid <= '0;
         dacValues <= '0;
         ampEnable <= '0;
         powerCtrl <= '0;
      end else begin
         // New block forgets whatever was staged before
         if (bwBlockWstart) begin
            stageValid <= '0;
         end else if (stageWr) begin
            stageValid[chan] <= 1'b1;
         end
         // Commit only the fields each staged quadlet asks for
         if (commitWr) begin
            for (int i = 0; i < NumMotors; i++) begin
               if (stageValid[i] && stageQ[i].dac.dacValid) begin
                  dacValues[16*i +: 16] <= stageQ[i].dac.dacValue;
               end
               if (stageValid[i] && stageQ[i].dac.ampEnMask) begin
                  ampEnable[i] <= stageQ[i].dac.ampEn;
               end
            end
         end
         if (powerWr) begin
            powerCtrl <= busQuad.ctrl.powerCtrl;
         end
      end
   end

endmodule

`default_nettype wire

/* src/rtWriteTop.sv */
// Real-time write path top: both receivers, link selector, block writer, board registers
`timescale 1ns/1ns
`default_nettype none

module rtWriteTop import rtWritePkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    fwBlockStart,
   input  logic                    fwQuadValid,
   input  logic [31:0]             fwQuadData,
   input  logic                    ethFrameStart,
   input  logic                    ethHalfValid,
   input  logic [15:0]             ethHalfData,
   output logic                    hostConflict,
   output logic                    dacUpdate,
   output logic                    rtBusy,
   output logic [16*NumMotors-1:0] dacValues,
   output logic [NumMotors-1:0]    ampEnable,
   output logic [CtrlBits-1:0]     powerCtrl
);

   // Receiver outputs
   logic                fwWriteEn;
   logic [AddrBits-1:0] fwWriteAddr;
   logic [31:0]         fwWriteData;
   logic                ethWriteEn;
   logic [AddrBits-1:0] ethWriteAddr;
   logic [31:0]         ethWriteData;
   // Selected real-time write stream
   logic                rtWriteEn;
   logic [AddrBits-1:0] rtWriteAddr;
   logic [31:0]         rtWriteData;
   // Local register bus
   logic                bwRegWen;
   logic                bwBlockWen;
   logic                bwBlockWstart;
   logic [7:0]          bwRegWaddr;
   logic [31:0]         bwRegWdata;

   fwRtReceiver fwRx (
      .clk(clk), .rst(rst), .fwBlockStart(fwBlockStart), .fwQuadValid(fwQuadValid),
      .fwQuadData(fwQuadData), .fwWriteEn(fwWriteEn), .fwWriteAddr(fwWriteAddr),
      .fwWriteData(fwWriteData));

   ethRtReceiver ethRx (
      .clk(clk), .rst(rst), .ethFrameStart(ethFrameStart), .ethHalfValid(ethHalfValid),
      .ethHalfData(ethHalfData), .ethWriteEn(ethWriteEn), .ethWriteAddr(ethWriteAddr),
      .ethWriteData(ethWriteData));

   rtSourceSelect srcSel (
      .clk(clk), .rst(rst), .fwWriteEn(fwWriteEn), .fwWriteAddr(fwWriteAddr),
      .fwWriteData(fwWriteData), .ethWriteEn(ethWriteEn), .ethWriteAddr(ethWriteAddr),
      .ethWriteData(ethWriteData), .rtWriteEn(rtWriteEn), .rtWriteAddr(rtWriteAddr),
      .rtWriteData(rtWriteData), .hostConflict(hostConflict));

   rtBlockWriter blockWr (
      .clk(clk), .rst(rst), .rtWriteEn(rtWriteEn), .rtWriteAddr(rtWriteAddr),
      .rtWriteData(rtWriteData), .bwRegWen(bwRegWen), .bwBlockWen(bwBlockWen),
      .bwBlockWstart(bwBlockWstart), .bwRegWaddr(bwRegWaddr), .bwRegWdata(bwRegWdata),
      .dacUpdate(dacUpdate), .rtBusy(rtBusy));

   boardRegisters boardRegs (
      .clk(clk), .rst(rst), .bwRegWen(bwRegWen), .bwBlockWen(bwBlockWen),
      .bwBlockWstart(bwBlockWstart), .bwRegWaddr(bwRegWaddr), .bwRegWdata(bwRegWdata),
      .dacValues(dacValues), .ampEnable(ampEnable), .powerCtrl(powerCtrl));

endmodule

`default_nettype wire

/* verification/rtWriteTop_properties.sv */
// Bound checks on register-bus strobe timing and the block writer's state after reset
`timescale 1ns/1ns
`default_nettype none

module rtWriteTopProperties (
   input  logic clk,
   input  logic rst,
   input  logic bwRegWen,
   input  logic bwBlockWstart,
   input  logic dacUpdate,
   input  logic rtBusy
);

   // Failures of the checks below, read by the testbench at the end
   int propErrors = 0;

   // Every register write is followed by a quiet cycle
   regWenSingle: assert property (@(posedge clk) disable iff (rst) bwRegWen |=> !bwRegWen)
      else begin
         $error("bwRegWen high in two consecutive cycles");
         propErrors++;
      end

   // Start strobe phase carries no register write
   startNoWrite: assert property (@(posedge clk) disable iff (rst)
      !(bwBlockWstart && bwRegWen))
      else begin
         $error("bwBlockWstart and bwRegWen high together");
         propErrors++;
      end

   // DAC update only marks a block start
   updateInStart: assert property (@(posedge clk) disable iff (rst) dacUpdate |-> bwBlockWstart)
      else begin
         $error("dacUpdate high without bwBlockWstart");
         propErrors++;
      end

   // Block writer comes out of reset idle
   idleAfterReset: assert property (@(posedge clk) rst |=> !rtBusy)
      else begin
         $error("rtBusy high in the cycle after reset");
         propErrors++;
      end

endmodule

`default_nettype wire

/* verification/rtWriteTb.sv */
// Testbench for rtWriteTop with clock, reset, LFSR stimulus, expected-state model and timeout
`timescale 1ns/1ns
`default_nettype none

module rtWriteTb import rtWritePkg::*; ();

   // Eight blocks of at most 50 cycles each and a wide margin
   localparam int CycleLimit = 2000;

   // One block of NumMotors DAC quadlets followed by the control quadlet
   typedef rtQuadletU blockT [NumMotors+1];

   logic                    clk = 1'b0;
   logic                    rst;
   logic                    fwBlockStart;
   logic                    fwQuadValid;
   logic [31:0]             fwQuadData;
   logic                    ethFrameStart;
   logic                    ethHalfValid;
   logic [15:0]             ethHalfData;
   logic                    hostConflict;
   logic                    dacUpdate;
   logic                    rtBusy;
   logic [16*NumMotors-1:0] dacValues;
   logic [NumMotors-1:0]    ampEnable;
   logic [CtrlBits-1:0]     powerCtrl;

   // Expected board state
   logic [16*NumMotors-1:0] expDac;
   logic [NumMotors-1:0]    expAmp;
   logic [CtrlBits-1:0]     expPower;
   logic                    expConflict;
   blockT                   blockQ;
   blockT                   otherQ;
   logic [15:0]             lfsr;
   int                      cycleCount = 0;
   // Cycles with dacUpdate high since the start
   int                      updateCycles = 0;
   int                      checkCount;
   int                      errCount;

   rtWriteTop UUT (
      .clk(clk), .rst(rst), .fwBlockStart(fwBlockStart), .fwQuadValid(fwQuadValid),
      .fwQuadData(fwQuadData), .ethFrameStart(ethFrameStart), .ethHalfValid(ethHalfValid),
      .ethHalfData(ethHalfData), .hostConflict(hostConflict), .dacUpdate(dacUpdate),
      .rtBusy(rtBusy), .dacValues(dacValues), .ampEnable(ampEnable), .powerCtrl(powerCtrl));

   bind rtWriteTop rtWriteTopProperties props (
      .clk(clk), .rst(rst), .bwRegWen(bwRegWen), .bwBlockWstart(bwBlockWstart),
      .dacUpdate(dacUpdate), .rtBusy(rtBusy));

   always #20 clk = ~clk;

   // Watchdog on the whole run
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CycleLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // dacUpdate sampled away from the driving edge
   always @(negedge clk) begin
      if (dacUpdate) begin
         updateCycles <= updateCycles + 1;
      end
   end

   // Fibonacci LFSR with taps 16 14 13 11 that returns the bit shifted out
   function automatic logic lfsrStep();
      logic outBit;
      logic fb;
      outBit = lfsr[15];
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return outBit;
   endfunction

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsrStep()};
      end
      return v;
   endfunction

   // Random block with at least one dacValid or ampEnMask where asked for
   task automatic makeBlock(input logic wantDac, input logic wantAmp, input logic wantCtrl);
      logic [31:0] r;
      logic        anyValid;
      logic        anyMask;
      anyValid = 1'b0;
      anyMask = 1'b0;
      for (int i = 0; i < NumMotors; i++) begin
         blockQ[i] = '0;
         r = randBits(16);
         blockQ[i].dac.dacValue = r[15:0];
         if (wantDac) begin
            blockQ[i].dac.dacValid = lfsrStep();
         end
         if (wantAmp) begin
            blockQ[i].dac.ampEnMask = lfsrStep();
            blockQ[i].dac.ampEn = lfsrStep();
         end
         anyValid = anyValid | blockQ[i].dac.dacValid;
         anyMask = anyMask | blockQ[i].dac.ampEnMask;
      end
      if (wantDac && !anyValid) begin
         blockQ[0].dac.dacValid = 1'b1;
      end
      if (wantAmp && !anyMask) begin
         blockQ[1].dac.ampEnMask = 1'b1;
      end
      // Upper control bits are random too and only the low 20 count
      r = randBits(32);
      blockQ[NumMotors] = r;
      if (!wantCtrl) begin
         blockQ[NumMotors].ctrl.powerCtrl = '0;
      end else if (blockQ[NumMotors].ctrl.powerCtrl == '0) begin
         blockQ[NumMotors].ctrl.powerCtrl = CtrlBits'(1);
      end
   endtask

   // Effect of an accepted block on the expected board state
   task automatic modelBlock(output logic expUpdate);
      logic anyWork;
      anyWork = 1'b0;
      expUpdate = 1'b0;
      for (int i = 0; i < NumMotors; i++) begin
         anyWork = anyWork | blockQ[i].dac.dacValid | blockQ[i].dac.ampEnMask;
         expUpdate = expUpdate | blockQ[i].dac.dacValid;
      end
      if (anyWork) begin
         for (int i = 0; i < NumMotors; i++) begin
            if (blockQ[i].dac.dacValid) begin
               expDac[16*i +: 16] = blockQ[i].dac.dacValue;
            end
            if (blockQ[i].dac.ampEnMask) begin
               expAmp[i] = blockQ[i].dac.ampEn;
            end
         end
         // Zero control word keeps the old power setting
         if (blockQ[NumMotors].ctrl.powerCtrl != '0) begin
            expPower = blockQ[NumMotors].ctrl.powerCtrl;
         end
      end else begin
         // Control quadlet written straight away
         expPower = blockQ[NumMotors].ctrl.powerCtrl;
      end
   endtask

   // Firewire block as a start pulse and then one quadlet per cycle
   task automatic sendFw(input blockT q);
      @(posedge clk);
      fwBlockStart <= 1'b1;
      for (int i = 0; i <= NumMotors; i++) begin
         @(posedge clk);
         fwBlockStart <= 1'b0;
         fwQuadValid <= 1'b1;
         fwQuadData <= q[i];
      end
      @(posedge clk);
      fwQuadValid <= 1'b0;
   endtask

   // Ethernet frame as a start pulse and then halfwords with the high half first
   task automatic sendEth(input blockT q);
      logic [31:0] word;
      @(posedge clk);
      ethFrameStart <= 1'b1;
      for (int i = 0; i <= NumMotors; i++) begin
         word = q[i];
         @(posedge clk);
         ethFrameStart <= 1'b0;
         ethHalfValid <= 1'b1;
         ethHalfData <= word[31:16];
         @(posedge clk);
         ethHalfData <= word[15:0];
      end
      @(posedge clk);
      ethHalfValid <= 1'b0;
   endtask

   // Block writer starts and goes idle again
   task automatic waitDone();
      do begin
         @(negedge clk);
      end while (!rtBusy);
      while (rtBusy) begin
         @(negedge clk);
      end
   endtask

   task automatic checkState(input logic expUpdate, input logic updateSeen);
      checkCount += 5;
      assert (dacValues == expDac) else begin
         $display("FAIL dacValues: got %h, expected %h", dacValues, expDac);
         errCount++;
      end
      assert (ampEnable == expAmp) else begin
         $display("FAIL ampEnable: got %h, expected %h", ampEnable, expAmp);
         errCount++;
      end
      assert (powerCtrl == expPower) else begin
         $display("FAIL powerCtrl: got %h, expected %h", powerCtrl, expPower);
         errCount++;
      end
      assert (updateSeen == expUpdate) else begin
         $display("FAIL dacUpdate seen: got %h, expected %h", updateSeen, expUpdate);
         errCount++;
      end
      assert (hostConflict == expConflict) else begin
         $display("FAIL hostConflict: got %h, expected %h", hostConflict, expConflict);
         errCount++;
      end
   endtask

   // One block over one link checked once the writer is idle
   task automatic runBlock(input logic viaEth, input logic wantDac, input logic wantAmp,
                           input logic wantCtrl);
      logic expUpdate;
      int   startCount;
      makeBlock(wantDac, wantAmp, wantCtrl);
      modelBlock(expUpdate);
      startCount = updateCycles;
      if (viaEth) begin
         sendEth(blockQ);
      end else begin
         sendFw(blockQ);
      end
      waitDone();
      checkState(expUpdate, updateCycles != startCount);
   endtask

   initial begin
      logic expUpdate;
      int   startCount;
      rst = 1'b1;
      fwBlockStart = 1'b0;
      fwQuadValid = 1'b0;
      fwQuadData = '0;
      ethFrameStart = 1'b0;
      ethHalfValid = 1'b0;
      ethHalfData = '0;
      lfsr = 16'd23161;
      expDac = '0;
      expAmp = '0;
      expPower = '0;
      expConflict = 1'b0;
      checkCount = 0;
      errCount = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checkState(1'b0, updateCycles != 0);

      // DAC blocks over each link with a zero control word
      runBlock(1'b0, 1'b1, 1'b0, 1'b0);
      runBlock(1'b1, 1'b1, 1'b0, 1'b0);
      // Control quadlet only
      runBlock(1'b0, 1'b0, 1'b0, 1'b1);
      // Amp enables and then mixed blocks
      runBlock(1'b1, 1'b0, 1'b1, 1'b0);
      runBlock(1'b0, 1'b1, 1'b1, 1'b0);
      runBlock(1'b1, 1'b1, 1'b1, 1'b1);
      runBlock(1'b0, 1'b0, 1'b1, 1'b1);

      // Ethernet frame one cycle behind a Firewire block while Firewire holds the grant
      makeBlock(1'b1, 1'b1, 1'b1);
      for (int i = 0; i <= NumMotors; i++) begin
         otherQ[i] = ~blockQ[i];
      end
      modelBlock(expUpdate);
      expConflict = 1'b1;
      startCount = updateCycles;
      fork
         sendFw(blockQ);
         begin
            @(posedge clk);
            sendEth(otherQ);
         end
      join
      waitDone();
      checkState(expUpdate, updateCycles != startCount);

      $display("Checks: %0d, errors: %0d, property errors: %0d",
               checkCount, errCount, UUT.props.propErrors);
      if (errCount == 0 && UUT.props.propErrors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtWrite.f */
src/rtWritePkg.sv
src/fwRtReceiver.sv
src/ethRtReceiver.sv
src/rtSourceSelect.sv
src/rtBlockWriter.sv
src/boardRegisters.sv
src/rtWriteTop.sv
verification/rtWriteTop_properties.sv
verification/rtWriteTb.sv

/* Makefile */
# Verilator build and run of the real-time write path testbench

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		--top-module rtWriteTb -Mdir obj_dir -f rtWrite.f

# Run and look for the pass line in the output
run: compile
	@out="$$(./obj_dir/VrtWriteTb)"; echo "$$out"; \
		echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir
